// File: run_sim.sh
#!/bin/sh
# compile and run the decode stage testbench with verilator

top=decode_stage_tb
obj_dir=obj_dir
log=sim.log

if ! verilator --binary --timing -f rv_decode.f --top-module "$top" -Mdir "$obj_dir"; then
  echo "verilator build failed"
  exit 1
fi

"./$obj_dir/V$top" > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "Test failed" "$log"; then
  exit 1
fi
if [ "$run_status" -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
if ! grep -q "Test passed" "$log"; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

// File: rv_decode.f
+incdir+testbench
verilog/rv_isa_pkg.sv
verilog/decode_pkg.sv
verilog/instr_decoder.sv
verilog/imm_gen.sv
verilog/reg_file.sv
verilog/hazard_unit.sv
verilog/decode_stage.sv
testbench/decode_stage_tb.sv

// File: testbench/decode_vectors.svh
`ifndef decode_vectors_svh
`define decode_vectors_svh

// columns: instr, alu_op, br_op, is_br, mem_op, mem_read, mem_write, reg_write,
//          alu_a_sel, alu_b_sel, result_sel, rs1_valid, rs2_valid, imm
// alu_op 0 nop 1 add 2 sub 3 sll 4 slt 5 sltu 6 xor 7 srl 8 sra 9 or 10 and
// br_op 0 false 1 true 2 eq 3 ne 4 lt 5 ge 6 ltu 7 geu, mem_op 0 b 1 h 2 w 4 bu 5 hu
// alu_a_sel 1 pc, alu_b_sel 1 imm, result_sel 0 alu 1 imm 2 pc_plus
typedef struct packed {
  logic [31:0] instr;
  logic [3:0]  alu_op;
  logic [2:0]  br_op;
  logic        is_br;
  logic [2:0]  mem_op;
  logic        mem_read;
  logic        mem_write;
  logic        reg_write;
  logic        alu_a_sel;
  logic        alu_b_sel;
  logic [1:0]  result_sel;
  logic        rs1_valid;
  logic        rs2_valid;
  logic [31:0] imm;
} vector_t;

localparam int num_vectors = 20;

localparam vector_t vectors [num_vectors] = '{
  '{32'h002081b3, 4'd1, 3'd0, 1'b0, 3'd0, 1'b0, 1'b0, 1'b1,
    1'b0, 1'b0, 2'd0, 1'b1, 1'b1, 32'h0000_0000},   // add x3, x1, x2
  '{32'h40208233, 4'd2, 3'd0, 1'b0, 3'd0, 1'b0, 1'b0, 1'b1,
    1'b0, 1'b0, 2'd0, 1'b1, 1'b1, 32'h0000_0000},   // sub x4, x1, x2
  '{32'h407352b3, 4'd8, 3'd0, 1'b0, 3'd0, 1'b0, 1'b0, 1'b1,
    1'b0, 1'b0, 2'd0, 1'b1, 1'b1, 32'h0000_0000},   // sra x5, x6, x7
  '{32'h00a4b433, 4'd5, 3'd0, 1'b0, 3'd0, 1'b0, 1'b0, 1'b1,
    1'b0, 1'b0, 2'd0, 1'b1, 1'b1, 32'h0000_0000},   // sltu x8, x9, x10
  '{32'hfff10093, 4'd1, 3'd0, 1'b0, 3'd0, 1'b0, 1'b0, 1'b1,
    1'b0, 1'b1, 2'd0, 1'b1, 1'b0, 32'hffff_ffff},   // addi x1, x2, -1
  '{32'h40725193, 4'd8, 3'd0, 1'b0, 3'd0, 1'b0, 1'b0, 1'b1,
    1'b0, 1'b1, 2'd0, 1'b1, 1'b0, 32'h0000_0407},   // srai x3, x4, 7
  '{32'h40010113, 4'd1, 3'd0, 1'b0, 3'd0, 1'b0, 1'b0, 1'b1,
    1'b0, 1'b1, 2'd0, 1'b1, 1'b0, 32'h0000_0400},   // addi, bit 30 set, still add
  '{32'h0ff0c393, 4'd6, 3'd0, 1'b0, 3'd0, 1'b0, 1'b0, 1'b1,
    1'b0, 1'b1, 2'd0, 1'b1, 1'b0, 32'h0000_00ff},   // xori x7, x1, 0xff
  '{32'h0080a283, 4'd1, 3'd0, 1'b0, 3'd2, 1'b1, 1'b0, 1'b1,
    1'b0, 1'b1, 2'd0, 1'b1, 1'b0, 32'h0000_0008},   // lw x5, 8(x1)
  '{32'hffc15303, 4'd1, 3'd0, 1'b0, 3'd5, 1'b1, 1'b0, 1'b1,
    1'b0, 1'b1, 2'd0, 1'b1, 1'b0, 32'hffff_fffc},   // lhu x6, -4(x2)
  '{32'h0020a623, 4'd1, 3'd0, 1'b0, 3'd2, 1'b0, 1'b1, 1'b0,
    1'b0, 1'b1, 2'd0, 1'b1, 1'b1, 32'h0000_000c},   // sw x2, 12(x1)
  '{32'hfe320fa3, 4'd1, 3'd0, 1'b0, 3'd0, 1'b0, 1'b1, 1'b0,
    1'b0, 1'b1, 2'd0, 1'b1, 1'b1, 32'hffff_ffff},   // sb x3, -1(x4)
  '{32'h00208863, 4'd1, 3'd2, 1'b1, 3'd0, 1'b0, 1'b0, 1'b0,
    1'b1, 1'b1, 2'd0, 1'b1, 1'b1, 32'h0000_0010},   // beq x1, x2, +16
  '{32'hfe41fce3, 4'd1, 3'd7, 1'b1, 3'd0, 1'b0, 1'b0, 1'b0,
    1'b1, 1'b1, 2'd0, 1'b1, 1'b1, 32'hffff_fff8},   // bgeu x3, x4, -8
  '{32'h001000ef, 4'd1, 3'd1, 1'b1, 3'd0, 1'b0, 1'b0, 1'b1,
    1'b1, 1'b1, 2'd2, 1'b0, 1'b0, 32'h0000_0800},   // jal x1, +2048
  '{32'h00408067, 4'd1, 3'd1, 1'b1, 3'd0, 1'b0, 1'b0, 1'b0,
    1'b0, 1'b1, 2'd2, 1'b1, 1'b0, 32'h0000_0004},   // jalr x0, 4(x1)
  '{32'h12345537, 4'd0, 3'd0, 1'b0, 3'd0, 1'b0, 1'b0, 1'b1,
    1'b0, 1'b0, 2'd1, 1'b0, 1'b0, 32'h1234_5000},   // lui x10, 0x12345
  '{32'hfffff597, 4'd1, 3'd0, 1'b0, 3'd0, 1'b0, 1'b0, 1'b1,
    1'b1, 1'b1, 2'd0, 1'b0, 1'b0, 32'hffff_f000},   // auipc x11, 0xfffff
  '{32'hffffffff, 4'd0, 3'd0, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0,
    1'b0, 1'b0, 2'd0, 1'b0, 1'b0, 32'h0000_0000},   // unknown opcode
  '{32'h00208033, 4'd1, 3'd0, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0,
    1'b0, 1'b0, 2'd0, 1'b1, 1'b1, 32'h0000_0000}    // add x0, x1, x2
};

`endif

// File: testbench/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;

  localparam int          clk_period   = 40;
  localparam int          reset_cycles = 4;
  localparam int          accept_limit = 16;
  localparam logic [31:0] lfsr_seed    = 32'h124f_318b;

  `include "decode_vectors.svh"

  localparam int watchdog_cycles = (num_vectors + 40) * 8;

  logic               clk;
  logic               rest;
  logic               fd_valid;
  decode_pkg::fetch_t fd;
  logic               fd_ready;
  logic               de_valid;
  decode_pkg::de_t    de;
  logic               de_ready;
  logic [31:0]        rs1_value;
  logic [31:0]        rs2_value;
  logic               flush;
  decode_pkg::wb_t    wb;

  logic [31:0] lfsr_state;
  logic [31:0] r0, r1, r2, r9, r12, r1_new;

  decode_stage #(
    .num_regs (32)
  ) DUT (
    .clk       (clk),
    .rest      (rest),
    .fd_valid  (fd_valid),
    .fd        (fd),
    .fd_ready  (fd_ready),
    .de_valid  (de_valid),
    .de        (de),
    .de_ready  (de_ready),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .flush     (flush),
    .wb        (wb)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
    $display("Test failed");
    $fatal(1, "watchdog");
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic draw_word(output logic [31:0] word);
    word = '0;
    for (int b = 0; b < 32; b++) begin
      lfsr_state = lfsr_step(lfsr_state);
      word = {word[30:0], lfsr_state[0]};   // one step per bit
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      $display("Test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // entered at a falling edge, returns at the falling edge after acceptance
  task automatic send_instr(input logic [31:0] instr, input logic [31:0] pc, input logic jump);
    int waited;
    waited = 0;
    fd.instr = instr;
    fd.pc    = pc;
    fd.jump  = jump;
    fd_valid = 1'b1;
    #(clk_period / 4);   // ready settles mid low phase
    while (!fd_ready) begin
      waited++;
      if (waited > accept_limit) begin
        $display("fd_ready stayed low for %0d cycles, 0x%08h never taken", accept_limit, instr);
        $display("Test failed");
        $fatal(1, "handshake");
      end
      @(negedge clk);
      #(clk_period / 4);
    end
    @(negedge clk);
    fd_valid = 1'b0;
  endtask

  task automatic write_reg(input rv_isa_pkg::reg_addr_t rd, input logic [31:0] data);
    wb.valid     = 1'b1;
    wb.rd        = rd;
    wb.reg_write = 1'b1;
    wb.data      = data;
    @(negedge clk);
    wb = '0;
  endtask

  task automatic check_row(input int i);
    vector_t v;
    v = vectors[i];
    check_value("de_valid", 32'(de_valid), 32'd1);
    check_value("de.ctrl.alu_op", 32'(de.ctrl.alu_op), 32'(v.alu_op));
    check_value("de.ctrl.br_op", 32'(de.ctrl.br_op), 32'(v.br_op));
    check_value("de.ctrl.is_br", 32'(de.ctrl.is_br), 32'(v.is_br));
    check_value("de.ctrl.mem_op", 32'(de.ctrl.mem_op), 32'(v.mem_op));
    check_value("de.ctrl.mem_read", 32'(de.ctrl.mem_read), 32'(v.mem_read));
    check_value("de.ctrl.mem_write", 32'(de.ctrl.mem_write), 32'(v.mem_write));
    check_value("de.ctrl.reg_write", 32'(de.ctrl.reg_write), 32'(v.reg_write));
    check_value("de.sel.alu_a_sel", 32'(de.sel.alu_a_sel), 32'(v.alu_a_sel));
    check_value("de.sel.alu_b_sel", 32'(de.sel.alu_b_sel), 32'(v.alu_b_sel));
    check_value("de.sel.result_sel", 32'(de.sel.result_sel), 32'(v.result_sel));
    check_value("de.rs1_valid", 32'(de.rs1_valid), 32'(v.rs1_valid));
    check_value("de.rs2_valid", 32'(de.rs2_valid), 32'(v.rs2_valid));
    check_value("de.imm", de.imm, v.imm);
    check_value("de.pc", de.pc, 32'h0000_1000 + 32'(i) * 32'd4);
    check_value("de.jump", 32'(de.jump), 32'(i[0]));
  endtask

  // --------------------------------------------------
  // scenario sequence
  // --------------------------------------------------
  initial begin
    lfsr_state = lfsr_seed;
    rest       = 1'b0;
    fd_valid   = 1'b0;
    fd         = '0;
    de_ready   = 1'b0;
    flush      = 1'b0;
    wb         = '0;

    repeat (reset_cycles) begin
      @(negedge clk);
      check_value("de_valid", 32'(de_valid), 32'd0);
      check_value("de.ctrl", 32'(de.ctrl), 32'(decode_pkg::ctrl_nop));
    end
    rest     = 1'b1;
    de_ready = 1'b1;
    @(negedge clk);
    check_value("de_valid", 32'(de_valid), 32'd0);
    check_value("de.ctrl", 32'(de.ctrl), 32'(decode_pkg::ctrl_nop));

    // decode table, jump toggles with the row
    for (int i = 0; i < num_vectors; i++) begin
      send_instr(vectors[i].instr, 32'h0000_1000 + 32'(i) * 32'd4, i[0]);
      check_row(i);
    end

    // register file through wb
    draw_word(r1);
    draw_word(r2);
    draw_word(r9);
    draw_word(r0);
    write_reg(5'd1, r1);
    write_reg(5'd2, r2);
    write_reg(5'd9, r9);
    write_reg(5'd0, r0);   // must be dropped
    send_instr(32'h002081b3, 32'h0000_2000, 1'b0);   // add x3, x1, x2
    check_value("rs1_value", rs1_value, r1);
    check_value("rs2_value", rs2_value, r2);
    send_instr(32'h009001b3, 32'h0000_2004, 1'b0);   // add x3, x0, x9
    check_value("rs1_value", rs1_value, 32'd0);
    check_value("rs2_value", rs2_value, r9);
    draw_word(r12);
    wb.valid     = 1'b1;
    wb.rd        = 5'd12;
    wb.reg_write = 1'b1;
    wb.data      = r12;
    send_instr(32'h000601b3, 32'h0000_2008, 1'b0);   // add x3, x12, x0 with write
    wb = '0;
    check_value("rs1_value", rs1_value, r12);
    check_value("rs2_value", rs2_value, 32'd0);

    // --------------------------------------------------
    // load-use
    // --------------------------------------------------
    send_instr(32'h0000a283, 32'h0000_3000, 1'b0);   // lw x5, 0(x1)
    check_value("de.ctrl.mem_read", 32'(de.ctrl.mem_read), 32'd1);
    fd.instr = 32'h00228333;   // add x6, x5, x2
    fd.pc    = 32'h0000_3004;
    fd.jump  = 1'b1;
    fd_valid = 1'b1;
    #(clk_period / 4);
    check_value("fd_ready", 32'(fd_ready), 32'd0);
    @(negedge clk);
    check_value("de_valid", 32'(de_valid), 32'd1);
    check_value("de.ctrl", 32'(de.ctrl), 32'(decode_pkg::ctrl_nop));
    check_value("de.jump", 32'(de.jump), 32'd0);
    #(clk_period / 4);
    check_value("fd_ready", 32'(fd_ready), 32'd1);
    @(negedge clk);
    fd_valid = 1'b0;
    check_value("de_valid", 32'(de_valid), 32'd1);
    check_value("de.ctrl.alu_op", 32'(de.ctrl.alu_op), 32'(decode_pkg::alu_add));
    check_value("de.ctrl.reg_write", 32'(de.ctrl.reg_write), 32'd1);
    check_value("de.ctrl.mem_read", 32'(de.ctrl.mem_read), 32'd0);
    check_value("de.rd", 32'(de.rd), 32'd6);
    check_value("de.rs1", 32'(de.rs1), 32'd5);
    check_value("de.rs2", 32'(de.rs2), 32'd2);
    check_value("de.pc", de.pc, 32'h0000_3004);
    check_value("de.jump", 32'(de.jump), 32'd1);

    // independent add after the load, no bubble
    send_instr(32'h0000a283, 32'h0000_3008, 1'b0);
    fd.instr = 32'h002083b3;   // add x7, x1, x2
    fd.pc    = 32'h0000_300c;
    fd.jump  = 1'b0;
    fd_valid = 1'b1;
    #(clk_period / 4);
    check_value("fd_ready", 32'(fd_ready), 32'd1);
    @(negedge clk);
    fd_valid = 1'b0;
    check_value("de.ctrl.alu_op", 32'(de.ctrl.alu_op), 32'(decode_pkg::alu_add));
    check_value("de.rd", 32'(de.rd), 32'd7);
    check_value("de.pc", de.pc, 32'h0000_300c);

    // --------------------------------------------------
    // back-pressure, then flush
    // --------------------------------------------------
    send_instr(32'h002081b3, 32'h0000_4000, 1'b0);   // add x3, x1, x2
    de_ready = 1'b0;
    fd.instr = 32'h0ff0c393;
    fd.pc    = 32'h0000_4004;
    fd_valid = 1'b1;
    draw_word(r1_new);
    wb.valid     = 1'b1;   // x1 changes under the stall
    wb.rd        = 5'd1;
    wb.reg_write = 1'b1;
    wb.data      = r1_new;
    repeat (3) begin
      #(clk_period / 4);
      check_value("fd_ready", 32'(fd_ready), 32'd0);
      @(negedge clk);
      wb = '0;
      check_value("de_valid", 32'(de_valid), 32'd1);
      check_value("de.pc", de.pc, 32'h0000_4000);
      check_value("de.ctrl.alu_op", 32'(de.ctrl.alu_op), 32'(decode_pkg::alu_add));
      check_value("rs1_value", rs1_value, r1);
      check_value("rs2_value", rs2_value, r2);
    end
    flush    = 1'b1;
    de_ready = 1'b1;   // load possible with fd_valid high, flush has priority
    @(negedge clk);
    check_value("de_valid", 32'(de_valid), 32'd0);
    flush    = 1'b0;
    fd_valid = 1'b0;
    @(negedge clk);
    check_value("de_valid", 32'(de_valid), 32'd0);

    $display("Test passed");
    $finish;
  end

endmodule

// File: verilog/decode_pkg.sv
package decode_pkg;

  // --------------------------------------------------
  // execute control encodings
  // --------------------------------------------------
  typedef enum logic [3:0] {
    alu_nop,
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

  typedef enum logic [2:0] {
    br_false,
    br_true,   // jal / jalr
    br_eq,
    br_ne,
    br_lt,
    br_ge,
    br_ltu,
    br_geu
  } br_op_t;

  // same code points as the load/store funct3
  typedef enum logic [2:0] {
    mem_b  = 3'b000,
    mem_h  = 3'b001,
    mem_w  = 3'b010,
    mem_bu = 3'b100,
    mem_hu = 3'b101
  } mem_op_t;

  typedef enum logic {a_rs1, a_pc} alu_a_sel_t;
  typedef enum logic {b_rs2, b_imm} alu_b_sel_t;
  typedef enum logic [1:0] {res_alu, res_imm, res_pc_plus} result_sel_t;

  // --------------------------------------------------
  // stage structs
  // --------------------------------------------------
  typedef struct packed {
    alu_op_t    alu_op;
    br_op_t     br_op;
    logic       is_br;
    mem_op_t    mem_op;
    logic       mem_read;
    logic       mem_write;
    logic       reg_write;
    logic       spare;
  } ctrl_t;

  typedef struct packed {
    alu_a_sel_t  alu_a_sel;
    alu_b_sel_t  alu_b_sel;
    result_sel_t result_sel;
  } sel_t;

  typedef struct packed {
    logic [rv_isa_pkg::xlen-1:0] pc;
    rv_isa_pkg::instr_t          instr;
    logic                        jump;    // fetch already redirected
  } fetch_t;

  typedef struct packed {
    logic                        valid;
    rv_isa_pkg::reg_addr_t       rd;
    logic                        reg_write;
    logic [rv_isa_pkg::xlen-1:0] data;
  } wb_t;

  typedef struct packed {
    logic [rv_isa_pkg::xlen-1:0] pc;
    logic [rv_isa_pkg::xlen-1:0] imm;
    rv_isa_pkg::reg_addr_t       rd;
    rv_isa_pkg::reg_addr_t       rs1;
    rv_isa_pkg::reg_addr_t       rs2;
    logic                        rs1_valid;
    logic                        rs2_valid;
    logic                        jump;
    ctrl_t                       ctrl;
    sel_t                        sel;
  } de_t;

  localparam ctrl_t ctrl_nop = '{
    alu_op:    alu_nop,
    br_op:     br_false,
    is_br:     1'b0,
    mem_op:    mem_b,
    mem_read:  1'b0,
    mem_write: 1'b0,
    reg_write: 1'b0,
    spare:     1'b0
  };

endpackage

// File: verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
  parameter int num_regs = 32
) (
  input  logic                        clk,
  input  logic                        rest,
  // fetch side
  input  logic                        fd_valid,
  input  decode_pkg::fetch_t          fd,
  output logic                        fd_ready,
  // execute side
  output logic                        de_valid,
  output decode_pkg::de_t             de,
  input  logic                        de_ready,
  output logic [rv_isa_pkg::xlen-1:0] rs1_value,
  output logic [rv_isa_pkg::xlen-1:0] rs2_value,
  input  logic                        flush,
  // write-back
  input  decode_pkg::wb_t             wb
);

  rv_isa_pkg::reg_addr_t       rd;
  rv_isa_pkg::reg_addr_t       rs1;
  rv_isa_pkg::reg_addr_t       rs2;
  decode_pkg::ctrl_t           ctrl;
  decode_pkg::sel_t            sel;
  logic                        rs1_valid;
  logic                        rs2_valid;
  logic [rv_isa_pkg::xlen-1:0] imm;
  logic                        insert_nop;
  logic                        load_en;   // de register free to take new data

  assign rd  = fd.instr[rv_isa_pkg::rd_lo  +: rv_isa_pkg::reg_addr_w];
  assign rs1 = fd.instr[rv_isa_pkg::rs1_lo +: rv_isa_pkg::reg_addr_w];
  assign rs2 = fd.instr[rv_isa_pkg::rs2_lo +: rv_isa_pkg::reg_addr_w];

  // --------------------------------------------------
  // handshake
  // --------------------------------------------------
  assign load_en  = !de_valid || de_ready;
  assign fd_ready = load_en && !insert_nop;   // bubble goes in, fetch holds

  // --------------------------------------------------
  // decode pipeline register
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      de_valid <= 1'b0;
      de.ctrl  <= decode_pkg::ctrl_nop;
      de.jump  <= 1'b0;
    end else if (flush) begin
      de_valid <= 1'b0;   // flush beats a load
    end else if (load_en) begin
      de_valid     <= fd_valid;
      de.pc        <= fd.pc;
      de.imm       <= imm;
      de.rd        <= rd;
      de.rs1       <= rs1;
      de.rs2       <= rs2;
      de.rs1_valid <= rs1_valid;
      de.rs2_valid <= rs2_valid;
      de.sel       <= sel;
      if (insert_nop) begin
        de.ctrl <= decode_pkg::ctrl_nop;
        de.jump <= 1'b0;
      end else begin
        de.ctrl <= ctrl;
        de.jump <= fd.jump;
      end
    end
  end

  // --------------------------------------------------
  // instances
  // --------------------------------------------------
  instr_decoder u_instr_decoder (
    .instr     (fd.instr),
    .ctrl      (ctrl),
    .sel       (sel),
    .rs1_valid (rs1_valid),
    .rs2_valid (rs2_valid)
  );

  imm_gen u_imm_gen (
    .instr (fd.instr),
    .imm   (imm)
  );

  // read enable follows the de load so values line up with de
  reg_file #(
    .num_regs (num_regs)
  ) u_reg_file (
    .clk       (clk),
    .rest      (rest),
    .rd_en     (load_en),
    .rs1       (rs1),
    .rs2       (rs2),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .wb        (wb)
  );

  hazard_unit u_hazard_unit (
    .rs1        (rs1),
    .rs1_valid  (rs1_valid),
    .rs2        (rs2),
    .rs2_valid  (rs2_valid),
    .de_valid   (de_valid),
    .de_rd      (de.rd),
    .de_ctrl    (de.ctrl),
    .insert_nop (insert_nop)
  );

endmodule

// File: verilog/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
  input  rv_isa_pkg::reg_addr_t rs1,
  input  logic                  rs1_valid,
  input  rv_isa_pkg::reg_addr_t rs2,
  input  logic                  rs2_valid,
  input  logic                  de_valid,
  input  rv_isa_pkg::reg_addr_t de_rd,
  input  decode_pkg::ctrl_t     de_ctrl,
  output logic                  insert_nop
);

  logic load_in_de;   // instruction ahead is a load with a target
  logic rs1_match;
  logic rs2_match;

  // --------------------------------------------------
  // load-use check against the de register
  // --------------------------------------------------
  // data only arrives after mem, so forwarding from
  // execute cannot cover this one
  assign load_in_de = de_valid && de_ctrl.mem_read && de_ctrl.reg_write;

  assign rs1_match = rs1_valid && (rs1 == de_rd);
  assign rs2_match = rs2_valid && (rs2 == de_rd);

  assign insert_nop = load_in_de && (rs1_match || rs2_match);

endmodule

// File: verilog/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
  input  rv_isa_pkg::instr_t          instr,
  output logic [rv_isa_pkg::xlen-1:0] imm
);

  rv_isa_pkg::opcode_t         opcode;
  logic [rv_isa_pkg::xlen-1:0] imm_i;
  logic [rv_isa_pkg::xlen-1:0] imm_s;
  logic [rv_isa_pkg::xlen-1:0] imm_b;
  logic [rv_isa_pkg::xlen-1:0] imm_u;
  logic [rv_isa_pkg::xlen-1:0] imm_j;

  assign opcode = instr[rv_isa_pkg::opcode_lo +: 7];

  // --------------------------------------------------
  // one candidate per format
  // --------------------------------------------------
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};   // low bits zero filled
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    case (opcode)
      rv_isa_pkg::op_op_imm,
      rv_isa_pkg::op_load,
      rv_isa_pkg::op_jalr:   imm = imm_i;
      rv_isa_pkg::op_store:  imm = imm_s;
      rv_isa_pkg::op_branch: imm = imm_b;
      rv_isa_pkg::op_lui,
      rv_isa_pkg::op_auipc:  imm = imm_u;
      rv_isa_pkg::op_jal:    imm = imm_j;
      default:               imm = '0;   // reg-reg and unknown
    endcase
  end

endmodule

// File: verilog/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
  input  rv_isa_pkg::instr_t instr,
  output decode_pkg::ctrl_t  ctrl,
  output decode_pkg::sel_t   sel,
  output logic               rs1_valid,
  output logic               rs2_valid
);

  rv_isa_pkg::opcode_t   opcode;
  rv_isa_pkg::funct3_t   funct3;
  rv_isa_pkg::funct7_t   funct7;
  rv_isa_pkg::reg_addr_t rd;
  logic                  write_rd;   // class writes rd, before the x0 check

  assign opcode = instr[rv_isa_pkg::opcode_lo +: 7];
  assign funct3 = instr[rv_isa_pkg::funct3_lo +: 3];
  assign funct7 = instr[rv_isa_pkg::funct7_lo +: 7];
  assign rd     = instr[rv_isa_pkg::rd_lo +: rv_isa_pkg::reg_addr_w];

  // --------------------------------------------------
  // funct3 lookups
  // --------------------------------------------------
  // sub only exists in the register form, sra in both
  function automatic decode_pkg::alu_op_t alu_op_of(rv_isa_pkg::funct3_t f3, logic alt,
                                                     logic reg_form);
    decode_pkg::alu_op_t op;
    case (f3)
      rv_isa_pkg::f3_add:  op = (alt && reg_form) ? decode_pkg::alu_sub : decode_pkg::alu_add;
      rv_isa_pkg::f3_sll:  op = decode_pkg::alu_sll;
      rv_isa_pkg::f3_slt:  op = decode_pkg::alu_slt;
      rv_isa_pkg::f3_sltu: op = decode_pkg::alu_sltu;
      rv_isa_pkg::f3_xor:  op = decode_pkg::alu_xor;
      rv_isa_pkg::f3_sr:   op = alt ? decode_pkg::alu_sra : decode_pkg::alu_srl;
      rv_isa_pkg::f3_or:   op = decode_pkg::alu_or;
      rv_isa_pkg::f3_and:  op = decode_pkg::alu_and;
    endcase
    return op;
  endfunction

  function automatic decode_pkg::br_op_t br_op_of(rv_isa_pkg::funct3_t f3);
    decode_pkg::br_op_t op;
    case (f3)
      rv_isa_pkg::f3_beq:  op = decode_pkg::br_eq;
      rv_isa_pkg::f3_bne:  op = decode_pkg::br_ne;
      rv_isa_pkg::f3_blt:  op = decode_pkg::br_lt;
      rv_isa_pkg::f3_bge:  op = decode_pkg::br_ge;
      rv_isa_pkg::f3_bltu: op = decode_pkg::br_ltu;
      rv_isa_pkg::f3_bgeu: op = decode_pkg::br_geu;
      default:             op = decode_pkg::br_false;   // 010/011 not defined
    endcase
    return op;
  endfunction

  function automatic decode_pkg::mem_op_t mem_op_of(rv_isa_pkg::funct3_t f3);
    decode_pkg::mem_op_t op;
    case (f3)
      rv_isa_pkg::f3_h:  op = decode_pkg::mem_h;
      rv_isa_pkg::f3_w:  op = decode_pkg::mem_w;
      rv_isa_pkg::f3_bu: op = decode_pkg::mem_bu;
      rv_isa_pkg::f3_hu: op = decode_pkg::mem_hu;
      default:           op = decode_pkg::mem_b;
    endcase
    return op;
  endfunction

  // --------------------------------------------------
  // opcode classes
  // --------------------------------------------------
  always_comb begin
    ctrl           = decode_pkg::ctrl_nop;
    sel.alu_a_sel  = decode_pkg::a_rs1;
    sel.alu_b_sel  = decode_pkg::b_rs2;
    sel.result_sel = decode_pkg::res_alu;
    rs1_valid      = 1'b0;
    rs2_valid      = 1'b0;
    write_rd       = 1'b0;
    case (opcode)
      rv_isa_pkg::op_op: begin
        ctrl.alu_op = alu_op_of(funct3, funct7[5], 1'b1);
        rs1_valid   = 1'b1;
        rs2_valid   = 1'b1;
        write_rd    = 1'b1;
      end
      rv_isa_pkg::op_op_imm: begin
        ctrl.alu_op   = alu_op_of(funct3, funct7[5], 1'b0);
        sel.alu_b_sel = decode_pkg::b_imm;
        rs1_valid     = 1'b1;
        write_rd      = 1'b1;
      end
      rv_isa_pkg::op_load: begin
        ctrl.alu_op   = decode_pkg::alu_add;   // address = rs1 + imm
        ctrl.mem_op   = mem_op_of(funct3);
        ctrl.mem_read = 1'b1;
        sel.alu_b_sel = decode_pkg::b_imm;
        rs1_valid     = 1'b1;
        write_rd      = 1'b1;
      end
      rv_isa_pkg::op_store: begin
        ctrl.alu_op    = decode_pkg::alu_add;
        ctrl.mem_op    = mem_op_of(funct3);
        ctrl.mem_write = 1'b1;
        sel.alu_b_sel  = decode_pkg::b_imm;
        rs1_valid      = 1'b1;
        rs2_valid      = 1'b1;
      end
      rv_isa_pkg::op_branch: begin
        ctrl.alu_op   = decode_pkg::alu_add;   // target = pc + imm
        ctrl.br_op    = br_op_of(funct3);
        ctrl.is_br    = 1'b1;
        sel.alu_a_sel = decode_pkg::a_pc;
        sel.alu_b_sel = decode_pkg::b_imm;
        rs1_valid     = 1'b1;
        rs2_valid     = 1'b1;
      end
      rv_isa_pkg::op_jal, rv_isa_pkg::op_jalr: begin
        ctrl.alu_op    = decode_pkg::alu_add;
        ctrl.br_op     = decode_pkg::br_true;
        ctrl.is_br     = 1'b1;
        sel.alu_a_sel  = (opcode == rv_isa_pkg::op_jal) ? decode_pkg::a_pc : decode_pkg::a_rs1;
        sel.alu_b_sel  = decode_pkg::b_imm;
        sel.result_sel = decode_pkg::res_pc_plus;   // link value
        rs1_valid      = (opcode == rv_isa_pkg::op_jalr);
        write_rd       = 1'b1;
      end
      rv_isa_pkg::op_lui: begin
        sel.result_sel = decode_pkg::res_imm;
        write_rd       = 1'b1;
      end
      rv_isa_pkg::op_auipc: begin
        ctrl.alu_op   = decode_pkg::alu_add;
        sel.alu_a_sel = decode_pkg::a_pc;
        sel.alu_b_sel = decode_pkg::b_imm;
        write_rd      = 1'b1;
      end
      default: ;   // unknown, stays a nop
    endcase
    ctrl.reg_write = write_rd && (rd != '0);
  end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
  parameter int num_regs = 32
) (
  input  logic                        clk,
  input  logic                        rest,
  input  logic                        rd_en,
  input  rv_isa_pkg::reg_addr_t       rs1,
  input  rv_isa_pkg::reg_addr_t       rs2,
  output logic [rv_isa_pkg::xlen-1:0] rs1_value,
  output logic [rv_isa_pkg::xlen-1:0] rs2_value,
  input  decode_pkg::wb_t             wb
);

  logic [rv_isa_pkg::xlen-1:0] regs [num_regs];
  logic                        wr_en;

  // x0 never written, upper registers absent on rv32e
  assign wr_en = wb.valid && wb.reg_write && (wb.rd != '0) && (wb.rd < num_regs);

  // same-cycle write wins over the stored word
  function automatic logic [rv_isa_pkg::xlen-1:0] read_word(rv_isa_pkg::reg_addr_t addr);
    if (addr == '0 || addr >= num_regs) return '0;
    if (wr_en && wb.rd == addr) return wb.data;
    return regs[addr];
  endfunction

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      regs      <= '{default: '0};
      rs1_value <= '0;
      rs2_value <= '0;
    end else begin
      if (wr_en) regs[wb.rd] <= wb.data;
      if (rd_en) begin   // hold while decode is stalled
        rs1_value <= read_word(rs1);
        rs2_value <= read_word(rs2);
      end
    end
  end

endmodule

// File: verilog/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  typedef logic [31:0]           instr_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;
  typedef logic [6:0]            opcode_t;
  typedef logic [2:0]            funct3_t;
  typedef logic [6:0]            funct7_t;

  // --------------------------------------------------
  // field positions, lsb of each field
  // --------------------------------------------------
  localparam int opcode_lo = 0;
  localparam int rd_lo     = 7;
  localparam int funct3_lo = 12;
  localparam int rs1_lo    = 15;
  localparam int rs2_lo    = 20;
  localparam int funct7_lo = 25;

  // base opcodes
  localparam opcode_t op_lui    = 7'b0110111;
  localparam opcode_t op_auipc  = 7'b0010111;
  localparam opcode_t op_jal    = 7'b1101111;
  localparam opcode_t op_jalr   = 7'b1100111;
  localparam opcode_t op_branch = 7'b1100011;
  localparam opcode_t op_load   = 7'b0000011;
  localparam opcode_t op_store  = 7'b0100011;
  localparam opcode_t op_op_imm = 7'b0010011;
  localparam opcode_t op_op     = 7'b0110011;

  // branch compares
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  // load / store widths
  localparam funct3_t f3_b  = 3'b000;
  localparam funct3_t f3_h  = 3'b001;
  localparam funct3_t f3_w  = 3'b010;
  localparam funct3_t f3_bu = 3'b100;
  localparam funct3_t f3_hu = 3'b101;

  // alu group, reg and imm forms share these
  localparam funct3_t f3_add  = 3'b000;
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_slt  = 3'b010;
  localparam funct3_t f3_sltu = 3'b011;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_sr   = 3'b101;   // srl / sra by funct7[5]
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;

endpackage
